// ==== game_config.svh ====
`ifndef GAME_CONFIG_SVH
`define GAME_CONFIG_SVH

// Framebuffer geometry
`define SCREEN_W        160
`define SCREEN_H        120
`define SCREEN_PIXELS   19200

// Player grid, one cell per tile
`define TILE            4
`define GRID_W          40
`define GRID_H          30

`define GREETING_COLOR  12'h00F
`define CLEAR_COLOR     12'h000
`define PLAYER_COLOR    12'hFF0
`define GAME_OVER_COLOR 12'hF00

// PS/2 arrow make codes, E0 prefix already stripped
`define KEY_LEFT        8'h6B
`define KEY_RIGHT       8'h74
`define KEY_UP          8'h75
`define KEY_DOWN        8'h72

`define PLAYER_START_X  20
`define PLAYER_START_Y  15

`endif

// ==== video_pkg.sv ====
`default_nettype none

package video_pkg;

    // Screen column, 0 to 159
    typedef logic [7:0] pixel_x_t;

    // Screen row, 0 to 119
    typedef logic [6:0] pixel_y_t;

    // 4 bits per channel
    typedef logic [11:0] color_t;

    // Row times screen width plus column
    typedef logic [14:0] fb_addr_t;

endpackage

`default_nettype wire

// ==== game_pkg.sv ====
`default_nettype none

package game_pkg;

    typedef logic [5:0] grid_x_t;     // Cell column, 0 to 39
    typedef logic [4:0] grid_y_t;     // Cell row, 0 to 29
    typedef logic [7:0] key_code_t;   // PS/2 make code

    typedef enum logic [1:0] {
        GREETING,
        PLAYING,
        GAME_OVER
    } game_state_t;

    // Steps of one playing frame
    typedef enum logic [2:0] {
        IDLE,
        CLEAR_SCREEN,
        UPDATE_POSITION,
        RENDER_PLAYER,
        UPDATE_VGA,
        FRAME_DONE
    } frame_state_t;

endpackage

`default_nettype wire

// ==== screen_fill.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "game_config.svh"

module screen_fill #(
    parameter video_pkg::color_t fill_color = `CLEAR_COLOR
) (
    input  wire logic                clock,
    input  wire logic                resetn,
    input  wire logic                enable,
    output logic                     finished,
    output video_pkg::color_t        data,
    output video_pkg::fb_addr_t      addr,
    output logic                     wren
);

    import video_pkg::*;

    fb_addr_t pixel_cnt;   // Next address to write
    logic     last;

    assign last = (pixel_cnt == fb_addr_t'(`SCREEN_PIXELS - 1));

    always_ff @(posedge clock) begin
        if (!resetn) begin
            pixel_cnt <= '0;
        end else if (enable) begin
            if (last)
                pixel_cnt <= '0;   // Ready for the next pass
            else
                pixel_cnt <= pixel_cnt + 1'b1;
        end
    end

    assign data     = fill_color;
    assign addr     = pixel_cnt;
    assign wren     = enable;           // One write per enabled cycle
    assign finished = enable && last;

endmodule

`default_nettype wire

// ==== player_mover.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "game_config.svh"

module player_mover (
    input  wire logic                clock,
    input  wire logic                resetn,
    input  wire logic                enable,
    input  wire game_pkg::key_code_t last_key_received,
    output logic                     finished,
    output game_pkg::grid_x_t        game_x,
    output game_pkg::grid_y_t        game_y
);

    import game_pkg::*;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            game_x <= grid_x_t'(`PLAYER_START_X);
            game_y <= grid_y_t'(`PLAYER_START_Y);
        end else if (enable) begin
            // One cell per frame, clamped at the grid edges
            case (last_key_received)
                `KEY_LEFT: begin
                    if (game_x != '0)
                        game_x <= game_x - 1'b1;
                end
                `KEY_RIGHT: begin
                    if (game_x != grid_x_t'(`GRID_W - 1))
                        game_x <= game_x + 1'b1;
                end
                `KEY_UP: begin
                    if (game_y != '0)
                        game_y <= game_y - 1'b1;
                end
                `KEY_DOWN: begin
                    if (game_y != grid_y_t'(`GRID_H - 1))
                        game_y <= game_y + 1'b1;
                end
                default: ;   // Non-arrow keys leave the player alone
            endcase
        end
    end

    assign finished = enable;   // Done in its single step

endmodule

`default_nettype wire

// ==== sprite_render.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "game_config.svh"

module sprite_render (
    input  wire logic                clock,
    input  wire logic                resetn,
    input  wire logic                enable,
    input  wire game_pkg::grid_x_t   game_x,
    input  wire game_pkg::grid_y_t   game_y,
    output logic                     finished,
    output video_pkg::color_t        data,
    output video_pkg::fb_addr_t      addr,
    output logic                     wren
);

    import video_pkg::*;

    logic [3:0] offset;   // Row in [3:2], column in [1:0]
    pixel_x_t   org_x;
    pixel_y_t   org_y;
    pixel_x_t   px;
    pixel_y_t   py;

    // Top-left pixel of the player cell
    assign org_x = pixel_x_t'(game_x * `TILE);
    assign org_y = pixel_y_t'(game_y * `TILE);

    assign px   = org_x + pixel_x_t'(offset[1:0]);
    assign py   = org_y + pixel_y_t'(offset[3:2]);
    assign addr = fb_addr_t'(py * `SCREEN_W + px);

    always_ff @(posedge clock) begin
        if (!resetn)
            offset <= '0;
        else if (enable)
            offset <= offset + 1'b1;   // Wraps to zero after the last pixel
    end

    assign data     = `PLAYER_COLOR;
    assign wren     = enable;
    assign finished = enable && (offset == 4'hF);

endmodule

`default_nettype wire

// ==== frame_scanout.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "game_config.svh"

module frame_scanout (
    input  wire logic                clock,
    input  wire logic                resetn,
    input  wire logic                enable,
    input  wire video_pkg::color_t   q,
    output logic                     finished,
    output video_pkg::fb_addr_t      addr,
    output video_pkg::pixel_x_t      vga_x,
    output video_pkg::pixel_y_t      vga_y,
    output video_pkg::color_t        vga_color,
    output logic                     vga_plot
);

    import video_pkg::*;

    pixel_x_t x_cnt;     // Next pixel to fetch
    pixel_y_t y_cnt;
    pixel_x_t x_d;       // Pixel whose data is on q
    pixel_y_t y_d;
    logic     valid;
    logic     issuing;
    logic     last;
    pixel_x_t sel_x;
    pixel_y_t sel_y;

    assign issuing = (y_cnt != pixel_y_t'(`SCREEN_H));   // Low on the drain cycle
    assign last    = valid && (x_d == pixel_x_t'(`SCREEN_W - 1))
                     && (y_d == pixel_y_t'(`SCREEN_H - 1));

    // While paused, keep reading the pixel in flight so q still holds it
    assign sel_x = (enable && issuing) ? x_cnt : x_d;
    assign sel_y = (enable && issuing) ? y_cnt : y_d;
    assign addr  = fb_addr_t'(sel_y * `SCREEN_W + sel_x);

    always_ff @(posedge clock) begin
        if (!resetn || (enable && last)) begin
            x_cnt <= '0;
            y_cnt <= '0;
            x_d   <= '0;
            y_d   <= '0;
            valid <= 1'b0;
        end else if (enable) begin
            valid <= issuing;
            if (issuing) begin
                x_d <= x_cnt;
                y_d <= y_cnt;
                if (x_cnt == pixel_x_t'(`SCREEN_W - 1)) begin
                    x_cnt <= '0;
                    y_cnt <= y_cnt + 1'b1;
                end else begin
                    x_cnt <= x_cnt + 1'b1;
                end
            end
        end
    end

    assign vga_plot  = enable && valid;
    assign vga_x     = vga_plot ? x_d : '0;
    assign vga_y     = vga_plot ? y_d : '0;
    assign vga_color = vga_plot ? q : '0;
    assign finished  = enable && last;   // With the final plot

endmodule

`default_nettype wire

// ==== play_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "game_config.svh"

module play_sequencer (
    input  wire logic                clock,
    input  wire logic                resetn,
    input  wire logic                enable,
    input  wire video_pkg::color_t   q,
    input  wire game_pkg::key_code_t last_key_received,
    output logic                     finished,
    output video_pkg::color_t        data,
    output video_pkg::fb_addr_t      addr,
    output logic                     wren,
    output video_pkg::pixel_x_t      vga_x,
    output video_pkg::pixel_y_t      vga_y,
    output video_pkg::color_t        vga_color,
    output logic                     vga_plot
);

    import video_pkg::*;
    import game_pkg::*;

    frame_state_t state, next_state;

    logic     e_clear, e_move, e_sprite, e_scan;
    logic     f_clear, f_move, f_sprite, f_scan;
    color_t   clr_data, spr_data, scan_color;
    fb_addr_t clr_addr, spr_addr, scan_addr;
    logic     clr_wren, spr_wren, scan_plot;
    pixel_x_t scan_x;
    pixel_y_t scan_y;
    grid_x_t  game_x;
    grid_y_t  game_y;

    always_ff @(posedge clock) begin
        if (!resetn)
            state <= IDLE;
        else if (enable)
            state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:            next_state = CLEAR_SCREEN;
            CLEAR_SCREEN:    if (f_clear) next_state = UPDATE_POSITION;
            UPDATE_POSITION: if (f_move) next_state = RENDER_PLAYER;
            RENDER_PLAYER:   if (f_sprite) next_state = UPDATE_VGA;
            UPDATE_VGA:      if (f_scan) next_state = FRAME_DONE;
            FRAME_DONE:      next_state = IDLE;
            default:         next_state = IDLE;
        endcase
    end

    // Stage enables follow the run level
    assign e_clear  = enable && (state == CLEAR_SCREEN);
    assign e_move   = enable && (state == UPDATE_POSITION);
    assign e_sprite = enable && (state == RENDER_PLAYER);
    assign e_scan   = enable && (state == UPDATE_VGA);
    assign finished = enable && (state == FRAME_DONE);

    always_comb begin
        data      = '0;
        addr      = '0;
        wren      = 1'b0;
        vga_x     = '0;
        vga_y     = '0;
        vga_color = '0;
        vga_plot  = 1'b0;
        case (state)
            CLEAR_SCREEN: begin
                data = clr_data;
                addr = clr_addr;
                wren = clr_wren;
            end
            RENDER_PLAYER: begin
                data = spr_data;
                addr = spr_addr;
                wren = spr_wren;
            end
            UPDATE_VGA: begin
                addr      = scan_addr;   // Read only, wren stays low
                vga_x     = scan_x;
                vga_y     = scan_y;
                vga_color = scan_color;
                vga_plot  = scan_plot;
            end
            default: ;
        endcase
    end

    screen_fill #(.fill_color(`CLEAR_COLOR)) clear_i (
        .clock(clock), .resetn(resetn), .enable(e_clear), .finished(f_clear),
        .data(clr_data), .addr(clr_addr), .wren(clr_wren)
    );

    player_mover mover_i (
        .clock(clock), .resetn(resetn), .enable(e_move), .finished(f_move),
        .last_key_received(last_key_received), .game_x(game_x), .game_y(game_y)
    );

    sprite_render sprite_i (
        .clock(clock), .resetn(resetn), .enable(e_sprite), .finished(f_sprite),
        .game_x(game_x), .game_y(game_y),
        .data(spr_data), .addr(spr_addr), .wren(spr_wren)
    );

    frame_scanout scan_i (
        .clock(clock), .resetn(resetn), .enable(e_scan), .finished(f_scan),
        .q(q), .addr(scan_addr), .vga_x(scan_x), .vga_y(scan_y),
        .vga_color(scan_color), .vga_plot(scan_plot)
    );

endmodule

`default_nettype wire

// ==== game_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "game_config.svh"

module game_top (
    input  wire logic                clock,
    input  wire logic                resetn,
    input  wire logic                enable,    // Run level, pauses everything
    input  wire video_pkg::color_t   q,
    input  wire game_pkg::key_code_t last_key_received,
    output video_pkg::color_t        data,
    output video_pkg::fb_addr_t      addr,
    output logic                     wren,
    output video_pkg::pixel_x_t      vga_x,
    output video_pkg::pixel_y_t      vga_y,
    output video_pkg::color_t        vga_color,
    output logic                     vga_plot
);

    import video_pkg::*;
    import game_pkg::*;

    game_state_t state, next_state;

    logic     e_greet, e_play, e_over;
    logic     f_greet, f_play, f_over;
    color_t   greet_data, play_data, over_data;
    fb_addr_t greet_addr, play_addr, over_addr;
    logic     greet_wren, play_wren, over_wren;
    pixel_x_t play_x;
    pixel_y_t play_y;
    color_t   play_color;
    logic     play_plot;

    always_ff @(posedge clock) begin
        if (!resetn)
            state <= GREETING;
        else
            state <= next_state;   // Strobes only fire while running
    end

    always_comb begin
        next_state = state;
        case (state)
            GREETING:  if (f_greet) next_state = PLAYING;
            PLAYING:   if (f_play) next_state = GAME_OVER;
            GAME_OVER: if (f_over) next_state = GREETING;
            default:   next_state = GREETING;
        endcase
    end

    assign e_greet = enable && (state == GREETING);
    assign e_play  = enable && (state == PLAYING);
    assign e_over  = enable && (state == GAME_OVER);

    always_comb begin
        data      = '0;
        addr      = '0;
        wren      = 1'b0;
        vga_x     = '0;
        vga_y     = '0;
        vga_color = '0;
        vga_plot  = 1'b0;
        case (state)
            GREETING: begin
                data = greet_data;
                addr = greet_addr;
                wren = greet_wren;
            end
            PLAYING: begin
                data      = play_data;
                addr      = play_addr;
                wren      = play_wren;
                vga_x     = play_x;     // Only the frame scanout plots
                vga_y     = play_y;
                vga_color = play_color;
                vga_plot  = play_plot;
            end
            GAME_OVER: begin
                data = over_data;
                addr = over_addr;
                wren = over_wren;
            end
            default: ;
        endcase
    end

    screen_fill #(.fill_color(`GREETING_COLOR)) greeting_i (
        .clock(clock), .resetn(resetn), .enable(e_greet), .finished(f_greet),
        .data(greet_data), .addr(greet_addr), .wren(greet_wren)
    );

    play_sequencer playing_i (
        .clock(clock), .resetn(resetn), .enable(e_play), .finished(f_play),
        .q(q), .last_key_received(last_key_received),
        .data(play_data), .addr(play_addr), .wren(play_wren),
        .vga_x(play_x), .vga_y(play_y), .vga_color(play_color), .vga_plot(play_plot)
    );

    screen_fill #(.fill_color(`GAME_OVER_COLOR)) game_over_i (
        .clock(clock), .resetn(resetn), .enable(e_over), .finished(f_over),
        .data(over_data), .addr(over_addr), .wren(over_wren)
    );

endmodule

`default_nettype wire

// ==== game_top_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module game_top_checker (
    input  wire logic clock,
    input  wire logic resetn,
    input  wire logic enable,
    input  wire logic wren,
    input  wire logic vga_plot
);

    int assert_failures = 0;   // Read by the testbench top

    // RAM port and VGA port never active in the same cycle
    write_or_plot: assert property (@(posedge clock) disable iff (!resetn)
        !(wren && vga_plot))
        else begin
            assert_failures++;
            $error("wren and vga_plot are high in the same cycle");
        end

    write_needs_run: assert property (@(posedge clock) disable iff (!resetn)
        wren |-> enable)
        else begin
            assert_failures++;
            $error("wren is high while enable is low");
        end

    plot_needs_run: assert property (@(posedge clock) disable iff (!resetn)
        vga_plot |-> enable)
        else begin
            assert_failures++;
            $error("vga_plot is high while enable is low");
        end

endmodule

`default_nettype wire

// ==== game_scoreboard.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "game_config.svh"

module game_scoreboard (
    input  wire logic                clock,
    input  wire logic                resetn,
    input  wire logic                enable,
    input  wire game_pkg::key_code_t last_key_received,
    input  wire video_pkg::color_t   data,
    input  wire video_pkg::fb_addr_t addr,
    input  wire logic                wren,
    input  wire video_pkg::pixel_x_t vga_x,
    input  wire video_pkg::pixel_y_t vga_y,
    input  wire video_pkg::color_t   vga_color,
    input  wire logic                vga_plot,
    output int                       mismatch_count,
    output int                       other_count,
    output int                       loops_done
);

    import video_pkg::*;
    import game_pkg::*;

    localparam int PH_GREET  = 0;
    localparam int PH_CLEAR  = 1;
    localparam int PH_SPRITE = 2;
    localparam int PH_SCAN   = 3;
    localparam int PH_OVER   = 4;

    int        phase;
    int        count;      // Events seen in the current phase
    int        model_x;    // Predicted player cell
    int        model_y;
    key_code_t frame_key;

    initial begin
        mismatch_count = 0;
        other_count    = 0;
        loops_done     = 0;
    end

    task automatic report_mismatch(input string name, input int expected, input int actual);
        mismatch_count++;
        $display("mismatch at %0t ns: %s expected %0h got %0h", $time, name, expected, actual);
    endtask

    task automatic report_failure(input string what);
        other_count++;
        $display("error at %0t ns: %s", $time, what);
    endtask

    task automatic move_player();
        case (frame_key)
            `KEY_LEFT:  if (model_x > 0) model_x--;
            `KEY_RIGHT: if (model_x < `GRID_W - 1) model_x++;
            `KEY_UP:    if (model_y > 0) model_y--;
            `KEY_DOWN:  if (model_y < `GRID_H - 1) model_y++;
            default: ;
        endcase
    endtask

    task automatic check_write();
        int     exp_addr;
        color_t exp_color;
        case (phase)
            PH_GREET, PH_CLEAR, PH_OVER: begin
                exp_addr  = count;   // Fills run through every address in order
                exp_color = (phase == PH_GREET) ? `GREETING_COLOR :
                            (phase == PH_CLEAR) ? `CLEAR_COLOR : `GAME_OVER_COLOR;
            end
            PH_SPRITE: begin
                exp_addr  = (model_y * `TILE + count / `TILE) * `SCREEN_W
                            + model_x * `TILE + count % `TILE;
                exp_color = `PLAYER_COLOR;
            end
            default: begin
                report_failure("framebuffer write during the scanout");
                return;
            end
        endcase
        if (addr != exp_addr)
            report_mismatch("addr", exp_addr, addr);
        if (data != exp_color)
            report_mismatch("data", exp_color, data);
        if (phase == PH_CLEAR && count == 0)
            frame_key = last_key_received;   // Key left behind by the greeting
        count++;
        if (phase == PH_SPRITE && count == `TILE * `TILE) begin
            phase = PH_SCAN;
            count = 0;
        end else if (phase != PH_SPRITE && count == `SCREEN_PIXELS) begin
            count = 0;
            if (phase == PH_CLEAR) begin
                move_player();
                phase = PH_SPRITE;
            end else if (phase == PH_OVER) begin
                loops_done++;
                phase = PH_GREET;
            end else begin
                phase = PH_CLEAR;
            end
        end
    endtask

    task automatic check_plot();
        int     exp_x;
        int     exp_y;
        color_t exp_color;
        if (phase != PH_SCAN) begin
            report_failure("VGA plot outside the scanout");
            return;
        end
        exp_x = count % `SCREEN_W;
        exp_y = count / `SCREEN_W;
        if (exp_x / `TILE == model_x && exp_y / `TILE == model_y)
            exp_color = `PLAYER_COLOR;
        else
            exp_color = `CLEAR_COLOR;
        if (vga_x != exp_x)
            report_mismatch("vga_x", exp_x, vga_x);
        if (vga_y != exp_y)
            report_mismatch("vga_y", exp_y, vga_y);
        if (vga_color != exp_color)
            report_mismatch("vga_color", exp_color, vga_color);
        count++;
        if (count == `SCREEN_PIXELS) begin
            phase = PH_OVER;
            count = 0;
        end
    endtask

    // Mid-cycle sampling, well away from the driving edge
    always @(negedge clock) begin
        if (!resetn) begin
            phase     = PH_GREET;
            count     = 0;
            model_x   = `PLAYER_START_X;
            model_y   = `PLAYER_START_Y;
            frame_key = '0;
        end else begin
            if (!enable && (wren || vga_plot))
                report_failure("write or plot while enable is low");
            if (wren && vga_plot)
                report_failure("write and plot in the same cycle");
            if (!vga_plot && (vga_x != 0 || vga_y != 0 || vga_color != 0))
                report_failure("VGA outputs are not zero without a plot");
            if (wren)
                check_write();
            else if (vga_plot)
                check_plot();
        end
    end

endmodule

`default_nettype wire

// ==== game_top_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "game_config.svh"

module game_top_tb;

    import video_pkg::*;
    import game_pkg::*;

    localparam int LOOP_CYCLES    = 76820;
    localparam int RUN_LOOPS      = 3;
    localparam int TIMEOUT_CYCLES = RUN_LOOPS * LOOP_CYCLES * 2;   // Room for the pauses

    logic      clock;
    logic      resetn;
    logic      enable;
    color_t    q;
    key_code_t last_key_received;
    color_t    data;
    fb_addr_t  addr;
    logic      wren;
    pixel_x_t  vga_x;
    pixel_y_t  vga_y;
    color_t    vga_color;
    logic      vga_plot;

    color_t mem [0:`SCREEN_PIXELS-1];   // Framebuffer RAM model
    int     cycle_count;
    int     mismatch_count;
    int     other_count;
    int     loops_done;

    function automatic key_code_t choose_key();
        case ($urandom % 5)
            0:       return `KEY_LEFT;
            1:       return `KEY_RIGHT;
            2:       return `KEY_UP;
            3:       return `KEY_DOWN;
            default: return 8'h1C;   // Not an arrow
        endcase
    endfunction

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Reset, then random run level and keys, all from one seeded process
    initial begin : reset_and_stimulus
        int i;
        void'($urandom(32'h20e4_9325));
        resetn            = 1'b0;
        enable            = 1'b0;
        q                 = '0;
        last_key_received = `KEY_RIGHT;
        cycle_count       = 0;
        for (i = 0; i < `SCREEN_PIXELS; i++)
            mem[i] = color_t'(i ^ (i >> 12) ^ 12'hA5A);   // Stale contents
        repeat (8) @(posedge clock);
        resetn <= 1'b1;
        forever begin
            @(posedge clock);
            enable <= ($urandom % 4) != 0;
            if (wren && data == `GREETING_COLOR && ($urandom % 1024) == 0)
                last_key_received <= choose_key();   // Only during the greeting
        end
    end

    // RAM with one cycle of read latency
    always @(posedge clock) begin
        if (wren)
            mem[addr] <= data;
        q <= mem[addr];
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    game_top game_top_i (
        .clock(clock), .resetn(resetn), .enable(enable), .q(q),
        .last_key_received(last_key_received),
        .data(data), .addr(addr), .wren(wren),
        .vga_x(vga_x), .vga_y(vga_y), .vga_color(vga_color), .vga_plot(vga_plot)
    );

    game_scoreboard scoreboard_i (
        .clock(clock), .resetn(resetn), .enable(enable),
        .last_key_received(last_key_received),
        .data(data), .addr(addr), .wren(wren),
        .vga_x(vga_x), .vga_y(vga_y), .vga_color(vga_color), .vga_plot(vga_plot),
        .mismatch_count(mismatch_count), .other_count(other_count), .loops_done(loops_done)
    );

    bind game_top game_top_checker checker_i (
        .clock(clock), .resetn(resetn), .enable(enable), .wren(wren), .vga_plot(vga_plot)
    );

    initial begin : run_control
        logic timed_out;
        int   assert_count;
        wait (resetn === 1'b1);
        while (loops_done < RUN_LOOPS && cycle_count < TIMEOUT_CYCLES)
            @(posedge clock);
        timed_out    = (loops_done < RUN_LOOPS);
        assert_count = game_top_i.checker_i.assert_failures;
        if (timed_out)
            $display("timeout: only %0d of %0d game loops done after %0d cycles",
                     loops_done, RUN_LOOPS, cycle_count);
        $display("errors: mismatches=%0d other=%0d assertions=%0d (cycles=%0d, loops=%0d)",
                 mismatch_count, other_count, assert_count, cycle_count, loops_done);
        if (timed_out || mismatch_count != 0 || other_count != 0 || assert_count != 0) begin
            $display("=== FAIL ===");
        end else begin
            $display("=== PASS ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== game_top.f ====
+incdir+.
video_pkg.sv
game_pkg.sv
screen_fill.sv
player_mover.sv
sprite_render.sv
frame_scanout.sv
play_sequencer.sv
game_top.sv
game_top_checker.sv
game_scoreboard.sv
game_top_tb.sv
